//--- load_unit.f
+incdir+rtl
rtl/load_unit_pkg.sv
rtl/ldbuf_if.sv
rtl/load_issue.sv
rtl/load_buffer.sv
rtl/load_align.sv
rtl/load_unit.sv
test/load_unit_assertions.sv
test/load_unit_tb.sv

//--- Makefile
# Verilator lint, build and run of the load unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
RUNFLAGS  = +verilator+error+limit+1000
TOP       = load_unit_tb
FILELIST  = load_unit.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/load_unit_tb.sv
/*
 * load unit testbench
 * random core loads, a cache model with random grant delay and
 * out-of-order responses, and checks of every retired value
 */

`timescale 1ns/10ps

`include "load_unit_defs.svh"

module load_unit_tb;
  import load_unit_pkg::*;

  localparam int n_loads     = 300;
  localparam int cycle_limit = n_loads * 30;
  localparam int n_tids      = 2 ** `LU_TRANS_ID_W;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i       = 1'b0;
  logic                  valid_i       = 1'b0;
  load_op_e              op_i          = LD;
  trans_id_t             trans_id_i    = '0;
  logic [`LU_ADDR_W-1:0] vaddr_i       = '0;
  logic                  data_gnt_i    = 1'b0;
  logic                  data_rvalid_i = 1'b0;
  ldbuf_id_t             data_rid_i    = '0;
  xlen_t                 data_rdata_i  = '0;
  logic                  pop_o;
  logic                  data_req_o;
  logic [`LU_ADDR_W-1:0] addr_o;
  logic [7:0]            be_o;
  logic [1:0]            size_o;
  ldbuf_id_t             data_id_o;
  logic                  valid_o;
  trans_id_t             trans_id_o;
  xlen_t                 result_o;

  // random source
  logic [31:0]             lfsr_q       = 32'hdfbeb9a2;
  // loads known to the core, by transaction id
  logic [n_tids-1:0]       tid_busy     = '0;
  load_op_e                tid_op   [n_tids];
  logic [31:0]             tid_addr [n_tids];
  // model of the request stage and of the buffer slots
  logic                    stage_valid  = 1'b0;
  trans_id_t               stage_tid    = '0;
  logic [`LU_NR_LDBUF-1:0] slot_busy    = '0;
  logic [`LU_NR_LDBUF-1:0] slot_flushed = '0;
  trans_id_t               slot_tid [`LU_NR_LDBUF];
  // cache model, granted ids waiting for data
  ldbuf_id_t               pend_id [$];
  logic [31:0]             pend_addr [$];
  int                      gnt_wait     = 0;
  int                      cycle_count  = 0;
  int                      accepted     = 0;
  int                      granted      = 0;
  int                      retired      = 0;
  int                      flushed_lds  = 0;
  int                      dropped      = 0;
  int                      errors       = 0;
  int                      assert_fails;
  logic                    run_done     = 1'b0;

  load_unit uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      value  = {value[30:0], lfsr_q[0]};
    end
    return value;
  endfunction

  // memory content folds every address byte
  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic xlen_t mem_dword(input logic [31:0] a);
    xlen_t dword;
    for (int k = 0; k < 8; k++) begin
      dword[8*k +: 8] = mem_byte(a + 32'(k));
    end
    return dword;
  endfunction

  function automatic int load_bytes(input load_op_e op);
    case (op)
      LW, LWU: return 4;
      LH, LHU: return 2;
      LB, LBU: return 1;
      default: return 8;
    endcase
  endfunction

  // bytes of the field, then sign fill above it
  function automatic xlen_t expected_result(input load_op_e op, input logic [31:0] a);
    xlen_t field;
    int    nbytes;
    logic  fill;
    field  = '0;
    nbytes = load_bytes(op);
    for (int k = 0; k < nbytes; k++) begin
      field[8*k +: 8] = mem_byte(a + 32'(k));
    end
    fill = (op == LW || op == LH || op == LB) && field[8*nbytes-1];
    for (int k = nbytes; k < 8; k++) begin
      field[8*k +: 8] = {8{fill}};
    end
    return field;
  endfunction

  function automatic logic [7:0] expected_be(input load_op_e op, input logic [31:0] a);
    logic [7:0] be;
    int         off;
    off = int'(a[2:0]);
    for (int k = 0; k < 8; k++) begin
      be[k] = (k >= off) && (k < off + load_bytes(op));
    end
    return be;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("ERR %0t: %s expected %h got %h", $time, what, exp_v, act_v);
    errors++;
  endtask

  // ------------------------------------------------------------------------
  // cycle model: look at the ending cycle, then drive the next one
  // ------------------------------------------------------------------------
  always @(posedge clk_i) begin : bench
    logic [31:0] rnd;
    logic [31:0] addr;
    load_op_e    op;
    trans_id_t   tid;
    logic        retire_exp;
    logic        found;
    int          idx;
    cycle_count++;
    if (rst_ni && !run_done) begin
      // response, retired only for a live slot outside a flush
      if (data_rvalid_i) begin
        retire_exp = !slot_flushed[data_rid_i] && !flush_i;
        tid        = slot_tid[data_rid_i];
        assert (valid_o == retire_exp)
          else report_mismatch("valid_o on response", 64'(retire_exp), 64'(valid_o));
        if (retire_exp) begin
          assert (trans_id_o == tid)
            else report_mismatch("trans_id_o", 64'(tid), 64'(trans_id_o));
          assert (tid_busy[trans_id_o])
            else report_mismatch("trans_id_o outstanding", 64'd1, 64'd0);
          assert (result_o == expected_result(tid_op[tid], tid_addr[tid]))
            else report_mismatch("result_o", expected_result(tid_op[tid], tid_addr[tid]),
                                 result_o);
          tid_busy[tid] = 1'b0;
        end else if (!slot_flushed[data_rid_i]) begin
          // flushed in its own response cycle
          tid_busy[tid] = 1'b0;
          flushed_lds++;
        end
        slot_busy[data_rid_i]    = 1'b0;
        slot_flushed[data_rid_i] = 1'b0;
      end
      // every retire the DUT signals, with or without a response
      if (valid_o) begin
        retired++;
      end
      // grant moves the staged load into the slot named by data_id_o
      if (data_req_o && data_gnt_i) begin
        assert (stage_valid && !slot_busy[data_id_o])
          else begin
            $display("cache grant at %0t with no staged load or a busy slot", $time);
            errors++;
          end
        assert (be_o == expected_be(tid_op[stage_tid], tid_addr[stage_tid]))
          else report_mismatch("be_o", 64'(expected_be(tid_op[stage_tid],
                               tid_addr[stage_tid])), 64'(be_o));
        assert (size_o == 2'($clog2(load_bytes(tid_op[stage_tid]))))
          else report_mismatch("size_o", 64'($clog2(load_bytes(tid_op[stage_tid]))),
                               64'(size_o));
        assert (addr_o == {tid_addr[stage_tid][31:3], 3'b000})
          else report_mismatch("addr_o", 64'({tid_addr[stage_tid][31:3], 3'b000}),
                               64'(addr_o));
        slot_busy[data_id_o]    = 1'b1;
        slot_flushed[data_id_o] = 1'b0;
        slot_tid[data_id_o]     = stage_tid;
        pend_id.push_back(data_id_o);
        pend_addr.push_back(addr_o);
        stage_valid = 1'b0;
        granted++;
        rnd      = take_bits(2);
        gnt_wait = int'(rnd[1:0]);
      end else if (data_req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
      if (valid_i && pop_o) begin
        stage_valid = 1'b1;
        stage_tid   = trans_id_i;
        accepted++;
      end
      // flush drops the staged load and marks every live slot
      if (flush_i) begin
        if (stage_valid) begin
          tid_busy[stage_tid] = 1'b0;
          stage_valid         = 1'b0;
          dropped++;
        end
        for (int s = 0; s < `LU_NR_LDBUF; s++) begin
          if (slot_busy[s] && !slot_flushed[s]) begin
            slot_flushed[s]       = 1'b1;
            tid_busy[slot_tid[s]] = 1'b0;
            flushed_lds++;
          end
        end
      end
      // core: hold an offer until pop, else maybe offer a new load
      if (!(valid_i && !pop_o)) begin
        valid_i <= 1'b0;
        found = 1'b0;
        for (int n = 0; n < n_tids; n++) begin
          if (!found && !tid_busy[n]) begin
            found = 1'b1;
            tid   = trans_id_t'(n);
          end
        end
        rnd = take_bits(2);
        if (found && accepted < n_loads && rnd[1:0] != 2'd0) begin
          rnd = take_bits(3);
          op  = (rnd[2:0] == 3'd7) ? LD : load_op_e'(rnd[2:0]);
          rnd = take_bits(32);
          // natural alignment for the access size
          addr = {rnd[31:3], rnd[2:0] & ~3'(load_bytes(op) - 1)};
          tid_busy[tid] = 1'b1;
          tid_op[tid]   = op;
          tid_addr[tid] = addr;
          valid_i    <= 1'b1;
          op_i       <= op;
          trans_id_i <= tid;
          vaddr_i    <= addr;
        end
      end
      rnd = take_bits(5);
      flush_i <= (accepted < n_loads) && (rnd[4:0] == 5'd0);
      // cache: grant after the drawn delay, answer a random pending id
      data_gnt_i    <= (gnt_wait == 0);
      data_rvalid_i <= 1'b0;
      if (pend_id.size() > 0) begin
        rnd = take_bits(3);
        if (rnd[0]) begin
          idx = int'(rnd[2:1]) % pend_id.size();
          data_rvalid_i <= 1'b1;
          data_rid_i    <= pend_id[idx];
          data_rdata_i  <= mem_dword(pend_addr[idx]);
          pend_id.delete(idx);
          pend_addr.delete(idx);
        end
      end
      // all loads accepted and every granted one answered
      if (accepted == n_loads && !stage_valid && slot_busy == '0 && pend_id.size() == 0) begin
        assert (granted == retired + flushed_lds && accepted == granted + dropped)
          else begin
            $display("load accounting broken: not every granted load retired or flushed");
            errors++;
          end
        run_done = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // reset, run and closing report
  // ------------------------------------------------------------------------
  initial begin : run
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (!run_done && cycle_count < cycle_limit) begin
      @(posedge clk_i);
    end
    if (!run_done) begin
      $display("timeout: run stopped after %0d cycles with %0d of %0d loads accepted",
               cycle_count, accepted, n_loads);
    end
    assert_fails = uut.u_assertions.fail_count;
    $display("loads %0d granted %0d retired %0d flushed %0d dropped %0d errors %0d asserts %0d",
             accepted, granted, retired, flushed_lds, dropped, errors, assert_fails);
    if (run_done && errors == 0 && assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- test/load_unit_assertions.sv
/*
 * load unit protocol checks, bound into the top level
 * reset, core handshake, cache req/gnt, back-pressure and flush rules
 */

`timescale 1ns/10ps

`include "load_unit_defs.svh"

module load_unit_assertions (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  flush_i,
  input logic                  valid_i,
  input logic                  pop_o,
  input logic                  data_req_o,
  input logic                  data_gnt_i,
  input logic [`LU_ADDR_W-1:0] addr_o,
  input logic [`LU_XLEN/8-1:0] be_o,
  input logic [1:0]            size_o,
  input logic                  data_rvalid_i,
  input logic                  valid_o
);

  // failed checks, read by the testbench at the end of the run
  int         fail_count = 0;
  // loads granted and not yet answered
  logic [2:0] in_flight_q;
  // no load offered by the core since reset
  logic       idle_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : in_flight_ff
    if (!rst_ni) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + 3'(data_req_o && data_gnt_i) - 3'(data_rvalid_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : idle_ff
    if (!rst_ni) begin
      idle_q <= 1'b1;
    end else if (valid_i) begin
      idle_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // core side
  // ------------------------------------------------------------------------
  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !pop_o && !data_req_o && !valid_o)
    else begin
      $error("pop, cache request or retire active during reset");
      fail_count++;
    end

  // nothing moves after reset until the core offers its first load
  idle_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_q && !valid_i |-> !pop_o && !data_req_o && !valid_o)
    else begin
      $error("pop, cache request or retire active before any load was offered");
      fail_count++;
    end

  // ------------------------------------------------------------------------
  // cache request
  // ------------------------------------------------------------------------

  // held request keeps its fields until the grant, unless flushed
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=>
      flush_i || (data_req_o && $stable(addr_o) && $stable(be_o) && $stable(size_o)))
    else begin
      $error("cache request dropped or changed while waiting for the grant");
      fail_count++;
    end

  full_blocks_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_flight_q == 3'(`LU_NR_LDBUF) |-> !data_req_o)
    else begin
      $error("cache request raised with every load buffer slot in use");
      fail_count++;
    end

  // ------------------------------------------------------------------------
  // flush and retire
  // ------------------------------------------------------------------------
  flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !pop_o && !data_req_o)
    else begin
      $error("pop or cache request active in a flush cycle");
      fail_count++;
    end

  retire_needs_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> data_rvalid_i)
    else begin
      $error("load retired without a cache response");
      fail_count++;
    end

endmodule

bind load_unit load_unit_assertions u_assertions (.*);

//--- rtl/load_unit.sv
/*
 * data cache load unit
 * issue stage, load buffer and result alignment behind plain ports;
 * several loads in flight, answered out of order by request id
 */

`timescale 1ns/10ps

`include "load_unit_defs.svh"

module load_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  // core request
  input  logic                      valid_i,
  input  load_unit_pkg::load_op_e   op_i,
  input  load_unit_pkg::trans_id_t  trans_id_i,
  input  logic [`LU_ADDR_W-1:0]     vaddr_i,
  output logic                      pop_o,
  // data cache request
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  output logic [`LU_ADDR_W-1:0]     addr_o,
  output logic [`LU_XLEN/8-1:0]     be_o,
  output logic [1:0]                size_o,
  output load_unit_pkg::ldbuf_id_t  data_id_o,
  // data cache response
  input  logic                      data_rvalid_i,
  input  load_unit_pkg::ldbuf_id_t  data_rid_i,
  input  load_unit_pkg::xlen_t      data_rdata_i,
  // retire
  output logic                      valid_o,
  output load_unit_pkg::trans_id_t  trans_id_o,
  output load_unit_pkg::xlen_t      result_o
);
  import load_unit_pkg::*;

  // entry of the answered slot
  ldbuf_entry_t rd_entry;

  ldbuf_if ldbuf ();

  // request id is the slot claimed on the grant
  assign data_id_o = ldbuf.id;

  load_issue i_load_issue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .trans_id_i (trans_id_i),
    .vaddr_i    (vaddr_i),
    .pop_o      (pop_o),
    .data_req_o (data_req_o),
    .data_gnt_i (data_gnt_i),
    .addr_o     (addr_o),
    .be_o       (be_o),
    .size_o     (size_o),
    .alloc      (ldbuf.issue)
  );

  load_buffer i_load_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rid_i    (data_rid_i),
    .valid_o       (valid_o),
    .trans_id_o    (trans_id_o),
    .entry_o       (rd_entry),
    .alloc         (ldbuf.buffer)
  );

  load_align i_load_align (
    .data_rdata_i (data_rdata_i),
    .entry_i      (rd_entry),
    .result_o     (result_o)
  );

endmodule

//--- rtl/load_align.sv
/*
 * load result alignment
 * moves the loaded field down to bit 0 and sign- or zero-extends it
 */

`timescale 1ns/10ps

`include "load_unit_defs.svh"

module load_align (
  input  load_unit_pkg::xlen_t         data_rdata_i,
  input  load_unit_pkg::ldbuf_entry_t  entry_i,
  output load_unit_pkg::xlen_t         result_o
);
  import load_unit_pkg::*;

  xlen_t                   shifted_data;
  logic [`LU_XLEN/8-1:0]   byte_msbs;
  logic [`LU_OFFSET_W-1:0] sign_offset;
  logic                    sign_bit;

  // ------------------------------------------------------------------------
  // shifter
  // ------------------------------------------------------------------------
  assign shifted_data = data_rdata_i >> {entry_i.offset, 3'b000};

  // ------------------------------------------------------------------------
  // sign bit, in parallel with the shifter
  // ------------------------------------------------------------------------

  // top bit of every byte lane
  for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_byte_msbs
    assign byte_msbs[i] = data_rdata_i[(i+1)*8-1];
  end

  // byte that holds the sign of the loaded field
  always_comb begin : sign_select
    case (entry_i.operation)
      LW, LWU: sign_offset = entry_i.offset + 3'd3;
      LH, LHU: sign_offset = entry_i.offset + 3'd1;
      default: sign_offset = entry_i.offset;
    endcase
  end

  // zero for unsigned loads
  assign sign_bit = is_signed(entry_i.operation) & byte_msbs[sign_offset];

  // ------------------------------------------------------------------------
  // result mux
  // ------------------------------------------------------------------------
  always_comb begin : result_mux
    case (entry_i.operation)
      LW, LWU: result_o = {{(`LU_XLEN - 32){sign_bit}}, shifted_data[31:0]};
      LH, LHU: result_o = {{(`LU_XLEN - 16){sign_bit}}, shifted_data[15:0]};
      LB, LBU: result_o = {{(`LU_XLEN - 8){sign_bit}}, shifted_data[7:0]};
      // LD passes the whole doubleword
      default: result_o = shifted_data;
    endcase
  end

endmodule

//--- rtl/load_buffer.sv
/*
 * load buffer
 * table of loads waiting for cache data, indexed by the cache request id;
 * finds the lowest free slot and looks up responses, flushed ones included
 */

`timescale 1ns/10ps

`include "load_unit_defs.svh"

module load_buffer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  // cache response
  input  logic                         data_rvalid_i,
  input  load_unit_pkg::ldbuf_id_t     data_rid_i,
  // retire side
  output logic                         valid_o,
  output load_unit_pkg::trans_id_t     trans_id_o,
  output load_unit_pkg::ldbuf_entry_t  entry_o,
  // slot allocation
  ldbuf_if.buffer                      alloc
);
  import load_unit_pkg::*;

  logic [`LU_NR_LDBUF-1:0] valid_q;
  logic [`LU_NR_LDBUF-1:0] valid_d;
  logic [`LU_NR_LDBUF-1:0] flushed_q;
  logic [`LU_NR_LDBUF-1:0] flushed_d;
  ldbuf_entry_t            entries_q [`LU_NR_LDBUF];
  ldbuf_entry_t            rd_entry;
  ldbuf_id_t               free_id;

  // ------------------------------------------------------------------------
  // free slot search
  // ------------------------------------------------------------------------

  // walk down so the lowest free slot wins
  always_comb begin : free_search
    free_id = '0;
    for (int i = `LU_NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id = ldbuf_id_t'(i);
      end
    end
  end

  assign alloc.id   = free_id;
  assign alloc.full = &valid_q;

  // ------------------------------------------------------------------------
  // slot state
  // ------------------------------------------------------------------------
  always_comb begin : slot_next
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // every load in flight becomes flushed
    if (flush_i) begin
      flushed_d = flushed_q | valid_q;
    end
    // response frees its slot, flushed or not
    if (data_rvalid_i) begin
      valid_d[data_rid_i]   = 1'b0;
      flushed_d[data_rid_i] = 1'b0;
    end
    // new load goes into a free slot, never the one being freed
    if (alloc.alloc) begin
      valid_d[alloc.id]   = 1'b1;
      flushed_d[alloc.id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : slot_ff
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  always_ff @(posedge clk_i) begin : entry_write
    if (alloc.alloc) begin
      entries_q[alloc.id] <= alloc.entry;
    end
  end

  // ------------------------------------------------------------------------
  // retire lookup
  // ------------------------------------------------------------------------
  assign rd_entry   = entries_q[data_rid_i];
  assign entry_o    = rd_entry;
  assign trans_id_o = rd_entry.trans_id;

  // a flush in the response cycle also drops that load
  assign valid_o = data_rvalid_i && !flushed_q[data_rid_i] && !flush_i;

endmodule

//--- rtl/load_issue.sv
/*
 * load issue stage
 * holds one load request and presents it to the data cache
 * with req/gnt, then claims a load buffer slot on the grant
 */

`timescale 1ns/10ps

`include "load_unit_defs.svh"

module load_issue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  // core request
  input  logic                      valid_i,
  input  load_unit_pkg::load_op_e   op_i,
  input  load_unit_pkg::trans_id_t  trans_id_i,
  input  logic [`LU_ADDR_W-1:0]     vaddr_i,
  output logic                      pop_o,
  // data cache request
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  output logic [`LU_ADDR_W-1:0]     addr_o,
  output logic [`LU_XLEN/8-1:0]     be_o,
  output logic [1:0]                size_o,
  // slot allocation
  ldbuf_if.issue                    alloc
);
  import load_unit_pkg::*;

  logic                    req_valid_q;
  load_op_e                req_op_q;
  trans_id_t               req_trans_id_q;
  logic [`LU_ADDR_W-1:0]   req_addr_q;
  logic [`LU_OFFSET_W-1:0] req_offset;
  logic [`LU_XLEN/8-1:0]   be_base;
  logic                    grant;
  logic                    accept;

  // ------------------------------------------------------------------------
  // request register
  // ------------------------------------------------------------------------

  // cache sees the request only with a free slot and no flush
  assign data_req_o = req_valid_q && !alloc.full && !flush_i;
  assign grant      = data_req_o && data_gnt_i;

  // take a new load when empty or emptying by this grant
  assign accept = valid_i && !flush_i && (!req_valid_q || grant);
  assign pop_o  = accept;

  always_ff @(posedge clk_i or negedge rst_ni) begin : req_valid_ff
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (flush_i) begin
      req_valid_q <= 1'b0;
    end else if (accept) begin
      req_valid_q <= 1'b1;
    end else if (grant) begin
      req_valid_q <= 1'b0;
    end
  end

  // payload follows the accept strobe only
  always_ff @(posedge clk_i) begin : req_payload_ff
    if (accept) begin
      req_op_q       <= op_i;
      req_trans_id_q <= trans_id_i;
      req_addr_q     <= vaddr_i;
    end
  end

  // ------------------------------------------------------------------------
  // cache request fields
  // ------------------------------------------------------------------------
  assign req_offset = req_addr_q[`LU_OFFSET_W-1:0];

  // doubleword aligned address
  assign addr_o = {req_addr_q[`LU_ADDR_W-1:`LU_OFFSET_W], {`LU_OFFSET_W{1'b0}}};
  assign size_o = transfer_size(req_op_q);

  // enables for the access size, moved up to the byte offset
  always_comb begin : be_gen
    case (size_o)
      2'd0:    be_base = 8'h01;
      2'd1:    be_base = 8'h03;
      2'd2:    be_base = 8'h0f;
      default: be_base = 8'hff;
    endcase
    be_o = be_base << req_offset;
  end

  // record the load in the buffer as the cache takes it
  assign alloc.alloc = grant;
  assign alloc.entry = '{trans_id: req_trans_id_q, offset: req_offset, operation: req_op_q};

endmodule

//--- rtl/ldbuf_if.sv
/*
 * load buffer allocation port
 * the issue stage claims the lowest free slot in its grant cycle
 */

`timescale 1ns/10ps

interface ldbuf_if;

  // write strobe, high only in a cache grant cycle
  logic                        alloc;
  // load to be recorded in the slot
  load_unit_pkg::ldbuf_entry_t entry;
  // lowest free slot, also the cache request id
  load_unit_pkg::ldbuf_id_t    id;
  // no free slot left
  logic                        full;

  // request side
  modport issue (
    output alloc,
    output entry,
    input  id,
    input  full
  );

  // table side
  modport buffer (
    input  alloc,
    input  entry,
    output id,
    output full
  );

endinterface

//--- rtl/load_unit_pkg.sv
/*
 * load unit types: load operations, id and data types,
 * the load buffer entry and the operation helpers
 */

`include "load_unit_defs.svh"

package load_unit_pkg;

  // integer load operations, 3 bit encoding
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } load_op_e;

  typedef logic [`LU_XLEN-1:0]       xlen_t;
  typedef logic [`LU_TRANS_ID_W-1:0] trans_id_t;
  typedef logic [`LU_LDBUF_ID_W-1:0] ldbuf_id_t;

  // one outstanding load, 9 bits
  typedef struct packed {
    trans_id_t               trans_id;
    logic [`LU_OFFSET_W-1:0] offset;
    load_op_e                operation;
  } ldbuf_entry_t;

  // size code: 0 byte, 1 half, 2 word, 3 double
  function automatic logic [1:0] transfer_size(load_op_e op);
    case (op)
      LW, LWU: return 2'd2;
      LH, LHU: return 2'd1;
      LB, LBU: return 2'd0;
      default: return 2'd3;
    endcase
  endfunction

  // sign-extending operations
  function automatic logic is_signed(load_op_e op);
    return op inside {LW, LH, LB};
  endfunction

endpackage

//--- rtl/load_unit_defs.svh
/*
 * load unit widths and load buffer depth
 * shared by the package and every RTL module of the load unit
 */

`ifndef LOAD_UNIT_DEFS_SVH
`define LOAD_UNIT_DEFS_SVH

// data path width of the core
`define LU_XLEN 64
// cache request address width
`define LU_ADDR_W 32
// core transaction id width
`define LU_TRANS_ID_W 3

// outstanding loads, two or more
`define LU_NR_LDBUF 4
// slot id width, also the cache request id width
`define LU_LDBUF_ID_W $clog2(`LU_NR_LDBUF)

// byte offset inside one doubleword
`define LU_OFFSET_W 3

`endif
